//--- verilog/lsu_settings.svh
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// ************************************************************
// data path widths
// ************************************************************
`define LSU_XLEN            64
`define LSU_ADDR_W          32

// ************************************************************
// address map
// ************************************************************
// cached window, both ends inclusive
// anything outside goes to the external bus
`define LSU_CACHED_BASE     32'h8000_0000
`define LSU_CACHED_LIMIT    32'h8800_0000

// ************************************************************
// buffering and local storage
// ************************************************************
`define LSU_FIFO_DEPTH      4
// one doubleword per entry, indexed by addr[10:3]
`define LSU_RAM_WORDS       256

`endif

//--- verilog/lsu_cmd_pkg.sv
`include "lsu_settings.svh"

package lsu_cmd_pkg;

    // ************************************************************
    // command side encodings
    // ************************************************************
    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } mem_op_e;

    // access size, log2 of the byte count
    typedef enum logic [1:0] {
        width_byte   = 2'd0,
        width_half   = 2'd1,
        width_word   = 2'd2,
        width_double = 2'd3
    } mem_width_e;

    // one load or store from the core side
    typedef struct packed {
        mem_op_e                 op;
        mem_width_e              width;
        logic                    is_signed;
        logic [`LSU_ADDR_W-1:0]  addr;
        logic [`LSU_XLEN-1:0]    wdata;
    } lsu_cmd_t;

    // one response per command, in command order
    typedef struct packed {
        logic                    is_store;
        logic                    uncached;
        logic [`LSU_XLEN-1:0]    rdata;
    } lsu_rsp_t;

endpackage

//--- verilog/mem_bus_pkg.sv
`include "lsu_settings.svh"

package mem_bus_pkg;

    // ************************************************************
    // bus side word and request
    // ************************************************************

    // same 64 bits, seen whole or as byte lanes
    typedef union packed {
        logic [`LSU_XLEN-1:0]            dword;
        logic [`LSU_XLEN/8-1:0][7:0]     lane;
    } bus_word_u;

    // formatted request as it sits in the queue
    typedef struct packed {
        logic                            we;
        logic                            uncached;
        logic [`LSU_ADDR_W-1:0]          addr;
        logic [`LSU_XLEN/8-1:0]          strb;
        bus_word_u                       wdata;
        // only needed to pick the load lanes on return
        lsu_cmd_pkg::mem_width_e         width;
        logic                            is_signed;
    } bus_req_t;

endpackage

//--- verilog/lsu_req_gen.sv
`include "lsu_settings.svh"

module lsu_req_gen (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   cmd_valid_i,
    input  lsu_cmd_pkg::lsu_cmd_t  cmd_i,
    output logic                   cmd_ready_o,
    input  logic                   fifo_full_i,
    output logic                   push_o,
    output mem_bus_pkg::bus_req_t  req_o
);
    localparam int OFF_W = $clog2(`LSU_XLEN / 8);

    logic                          occupied_q;
    logic                          accept;
    logic                          uncached;
    logic [OFF_W-1:0]              offset;
    logic [`LSU_XLEN/8-1:0]        strb;
    logic [`LSU_XLEN-1:0]          lane_data;
    mem_bus_pkg::bus_req_t         req_d;
    mem_bus_pkg::bus_req_t         req_q;

    // one-entry holding register, refilled in the cycle it drains
    assign push_o      = occupied_q && !fifo_full_i;
    assign cmd_ready_o = !occupied_q || push_o;
    assign accept      = cmd_valid_i && cmd_ready_o;

    // region decode
    assign uncached = (cmd_i.addr < `LSU_CACHED_BASE) || (cmd_i.addr > `LSU_CACHED_LIMIT);
    assign offset   = cmd_i.addr[OFF_W-1:0];

    // strobe from size and offset, store data copied into every lane
    always_comb begin
        case (cmd_i.width)
            lsu_cmd_pkg::width_byte: begin
                strb      = 8'b0000_0001 << offset;
                lane_data = {(`LSU_XLEN / 8){cmd_i.wdata[7:0]}};
            end
            lsu_cmd_pkg::width_half: begin
                strb      = 8'b0000_0011 << offset;
                lane_data = {(`LSU_XLEN / 16){cmd_i.wdata[15:0]}};
            end
            lsu_cmd_pkg::width_word: begin
                strb      = 8'b0000_1111 << offset;
                lane_data = {(`LSU_XLEN / 32){cmd_i.wdata[31:0]}};
            end
            default: begin
                strb      = '1;
                lane_data = cmd_i.wdata;
            end
        endcase
    end

    always_comb begin
        req_d.we          = (cmd_i.op == lsu_cmd_pkg::op_store);
        req_d.uncached    = uncached;
        req_d.addr        = cmd_i.addr;
        req_d.strb        = strb;
        req_d.wdata.dword = lane_data;
        req_d.width       = cmd_i.width;
        req_d.is_signed   = cmd_i.is_signed;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            occupied_q <= 1'b0;
        end else if (accept) begin
            occupied_q <= 1'b1;
        end else if (push_o) begin
            occupied_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_d;
        end
    end

    assign req_o = req_q;

endmodule

//--- verilog/lsu_req_fifo.sv
`include "lsu_settings.svh"

module lsu_req_fifo #(
    parameter int DEPTH = `LSU_FIFO_DEPTH
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   push_i,
    input  mem_bus_pkg::bus_req_t  req_i,
    output logic                   full_o,
    input  logic                   pop_i,
    output logic                   not_empty_o,
    output mem_bus_pkg::bus_req_t  head_o
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    mem_bus_pkg::bus_req_t         entries [0:DEPTH-1];
    logic [PTR_W-1:0]              wr_ptr_q;
    logic [PTR_W-1:0]              rd_ptr_q;
    logic [CNT_W-1:0]              count_q;

    // wrap without assuming a power of two depth
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o      = (count_q == CNT_W'(DEPTH));
    assign not_empty_o = (count_q != '0);
    assign head_o      = entries[rd_ptr_q];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            count_q <= count_q + CNT_W'(push_i) - CNT_W'(pop_i);
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (push_i) begin
            entries[wr_ptr_q] <= req_i;
        end
    end

endmodule

//--- verilog/lsu_mem_port.sv
`include "lsu_settings.svh"

module lsu_mem_port (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    not_empty_i,
    input  mem_bus_pkg::bus_req_t   head_i,
    output logic                    pop_o,
    output logic                    ext_req_valid_o,
    output mem_bus_pkg::bus_req_t   ext_req_o,
    input  logic                    ext_req_ready_i,
    input  logic                    ext_rsp_valid_i,
    input  mem_bus_pkg::bus_word_u  ext_rdata_i,
    output logic                    rsp_valid_o,
    output lsu_cmd_pkg::lsu_rsp_t   rsp_o
);
    localparam int OFF_W = $clog2(`LSU_XLEN / 8);
    localparam int IDX_W = $clog2(`LSU_RAM_WORDS);

    typedef enum logic [1:0] {
        st_idle,
        st_ext_req,
        st_ext_wait
    } state_e;

    state_e                         state_q;
    state_e                         state_d;
    logic                           local_go;
    logic                           ext_go;
    logic                           ext_done;
    logic [IDX_W-1:0]               ram_idx;
    mem_bus_pkg::bus_word_u         ram [0:`LSU_RAM_WORDS-1];
    mem_bus_pkg::bus_req_t          ext_q;

    // response stage
    logic                           rsp_valid_q;
    logic                           rsp_we_q;
    logic                           rsp_unc_q;
    lsu_cmd_pkg::mem_width_e        rsp_width_q;
    logic                           rsp_signed_q;
    logic [OFF_W-1:0]               rsp_off_q;
    mem_bus_pkg::bus_word_u         rsp_word_q;

    // pick the addressed lanes and extend to full width
    function automatic logic [`LSU_XLEN-1:0] extract_load(
        input mem_bus_pkg::bus_word_u  word,
        input logic [OFF_W-1:0]        off,
        input lsu_cmd_pkg::mem_width_e width,
        input logic                    is_signed
    );
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] w;
        b = word.lane[off];
        h = {word.lane[off + OFF_W'(1)], word.lane[off]};
        w = {word.lane[off + OFF_W'(3)], word.lane[off + OFF_W'(2)], h};
        case (width)
            lsu_cmd_pkg::width_byte:
                return {{(`LSU_XLEN - 8){is_signed & b[7]}}, b};
            lsu_cmd_pkg::width_half:
                return {{(`LSU_XLEN - 16){is_signed & h[15]}}, h};
            lsu_cmd_pkg::width_word:
                return {{(`LSU_XLEN - 32){is_signed & w[31]}}, w};
            default:
                return word.dword;
        endcase
    endfunction

    // ************************************************************
    // head dispatch, local RAM or external bus
    // ************************************************************
    assign pop_o    = (state_q == st_idle) && not_empty_i;
    assign local_go = pop_o && !head_i.uncached;
    assign ext_go   = pop_o && head_i.uncached;
    assign ext_done = (state_q == st_ext_wait) && ext_rsp_valid_i;
    assign ram_idx  = head_i.addr[OFF_W +: IDX_W];

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle:     if (ext_go) state_d = st_ext_req;
            st_ext_req:  if (ext_req_ready_i) state_d = st_ext_wait;
            st_ext_wait: if (ext_rsp_valid_i) state_d = st_idle;
            default:     state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= st_idle;
            rsp_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            rsp_valid_q <= local_go || ext_done;
        end
    end

    // held stable on the bus until the slave takes it
    always_ff @(posedge clk) begin
        if (ext_go) begin
            ext_q <= head_i;
        end
    end

    // strobe-merged write into the local RAM
    always_ff @(posedge clk) begin
        if (local_go && head_i.we) begin
            for (int i = 0; i < `LSU_XLEN / 8; i++) begin
                if (head_i.strb[i]) begin
                    ram[ram_idx].lane[i] <= head_i.wdata.lane[i];
                end
            end
        end
    end

    // ************************************************************
    // response capture
    // ************************************************************
    always_ff @(posedge clk) begin
        if (local_go) begin
            rsp_word_q   <= ram[ram_idx];
            rsp_we_q     <= head_i.we;
            rsp_unc_q    <= head_i.uncached;
            rsp_width_q  <= head_i.width;
            rsp_signed_q <= head_i.is_signed;
            rsp_off_q    <= head_i.addr[OFF_W-1:0];
        end else if (ext_done) begin
            rsp_word_q   <= ext_rdata_i;
            rsp_we_q     <= ext_q.we;
            rsp_unc_q    <= ext_q.uncached;
            rsp_width_q  <= ext_q.width;
            rsp_signed_q <= ext_q.is_signed;
            rsp_off_q    <= ext_q.addr[OFF_W-1:0];
        end
    end

    assign ext_req_valid_o = (state_q == st_ext_req);
    assign ext_req_o       = ext_q;
    assign rsp_valid_o     = rsp_valid_q;

    // stores answer with zero data
    always_comb begin
        rsp_o.is_store = rsp_we_q;
        rsp_o.uncached = rsp_unc_q;
        rsp_o.rdata    = rsp_we_q ? '0
                       : extract_load(rsp_word_q, rsp_off_q, rsp_width_q, rsp_signed_q);
    end

endmodule

//--- verilog/lsu_top.sv
module lsu_top (
    input  logic                    clk,
    input  logic                    rst_n_i,

    // command side
    input  logic                    cmd_valid_i,
    input  lsu_cmd_pkg::lsu_cmd_t   cmd_i,
    output logic                    cmd_ready_o,

    // response side
    output logic                    rsp_valid_o,
    output lsu_cmd_pkg::lsu_rsp_t   rsp_o,

    // external bus for the uncached region
    output logic                    ext_req_valid_o,
    output mem_bus_pkg::bus_req_t   ext_req_o,
    input  logic                    ext_req_ready_i,
    input  logic                    ext_rsp_valid_i,
    input  mem_bus_pkg::bus_word_u  ext_rdata_i
);

    // ************************************************************
    // producer -> queue
    // ************************************************************
    logic                           gen_push;
    mem_bus_pkg::bus_req_t          gen_req;
    logic                           fifo_full;

    lsu_req_gen u_req_gen (
        .clk             ( clk             ),
        .rst_n_i         ( rst_n_i         ),
        .cmd_valid_i     ( cmd_valid_i     ),
        .cmd_i           ( cmd_i           ),
        .cmd_ready_o     ( cmd_ready_o     ),
        .fifo_full_i     ( fifo_full       ),
        .push_o          ( gen_push        ),
        .req_o           ( gen_req         )
    );

    // ************************************************************
    // queue -> consumer
    // ************************************************************
    logic                           fifo_not_empty;
    mem_bus_pkg::bus_req_t          fifo_head;
    logic                           port_pop;

    lsu_req_fifo u_req_fifo (
        .clk             ( clk             ),
        .rst_n_i         ( rst_n_i         ),
        .push_i          ( gen_push        ),
        .req_i           ( gen_req         ),
        .full_o          ( fifo_full       ),
        .pop_i           ( port_pop        ),
        .not_empty_o     ( fifo_not_empty  ),
        .head_o          ( fifo_head       )
    );

    lsu_mem_port u_mem_port (
        .clk             ( clk             ),
        .rst_n_i         ( rst_n_i         ),
        .not_empty_i     ( fifo_not_empty  ),
        .head_i          ( fifo_head       ),
        .pop_o           ( port_pop        ),
        .ext_req_valid_o ( ext_req_valid_o ),
        .ext_req_o       ( ext_req_o       ),
        .ext_req_ready_i ( ext_req_ready_i ),
        .ext_rsp_valid_i ( ext_rsp_valid_i ),
        .ext_rdata_i     ( ext_rdata_i     ),
        .rsp_valid_o     ( rsp_valid_o     ),
        .rsp_o           ( rsp_o           )
    );

endmodule

//--- test/lsu_top_chk.sv
module lsu_top_chk (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   ext_req_valid_o,
    input  logic                   ext_req_ready_i,
    input  mem_bus_pkg::bus_req_t  ext_req_o,
    input  logic                   rsp_valid_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;

    // ************************************************************
    // external bus handshake
    // ************************************************************
    // a stalled request keeps valid and its payload
    property req_held;
        @(posedge clk) disable iff (!rst_n_i)
            ext_req_valid_o && !ext_req_ready_i |=> ext_req_valid_o && $stable(ext_req_o);
    endproperty

    property store_has_strobe;
        @(posedge clk) disable iff (!rst_n_i)
            ext_req_valid_o && ext_req_o.we |-> ext_req_o.strb != '0;
    endproperty

    // ************************************************************
    // response side
    // ************************************************************
    property quiet_in_reset;
        @(posedge clk) !rst_n_i |-> !rsp_valid_o;
    endproperty

    a_req_held: assert property (req_held)
        else begin
            fail_cnt++;
            $error("external request dropped or changed before it was accepted");
        end
    a_store_strb: assert property (store_has_strobe)
        else begin
            fail_cnt++;
            $error("external store issued with an empty byte strobe");
        end
    a_reset_rsp: assert property (quiet_in_reset)
        else begin
            fail_cnt++;
            $error("response valid raised while in reset");
        end

endmodule

//--- test/lsu_top_tb.sv
`include "lsu_settings.svh"

module lsu_top_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          NUM_CMDS   = 400;
    localparam int          PRELOAD    = 16;
    // up to 14 cycles per command on a slow slave, plus margin
    localparam int          MAX_CYCLES = NUM_CMDS * 14 + 400;
    localparam logic [31:0] SEED       = 32'h3f09a00d;

    logic                    clk = 1'b0;
    logic                    rst_n_i;
    logic                    cmd_valid_i;
    lsu_cmd_pkg::lsu_cmd_t   cmd_i;
    logic                    cmd_ready_o;
    logic                    rsp_valid_o;
    lsu_cmd_pkg::lsu_rsp_t   rsp_o;
    logic                    ext_req_valid_o;
    mem_bus_pkg::bus_req_t   ext_req_o;
    logic                    ext_req_ready_i = 1'b0;
    logic                    ext_rsp_valid_i = 1'b0;
    mem_bus_pkg::bus_word_u  ext_rdata_i = '0;

    // reference model state and slave memory
    logic [63:0]             ref_ram [0:`LSU_RAM_WORDS-1];
    logic [63:0]             ref_ext [logic [31:0]];
    logic [63:0]             slave_mem [logic [31:0]];
    lsu_cmd_pkg::lsu_rsp_t   exp_q [$];
    mem_bus_pkg::bus_req_t   ext_exp_q [$];
    lsu_cmd_pkg::lsu_rsp_t   exp_rsp;
    mem_bus_pkg::bus_req_t   exp_req;
    logic [63:0]             slave_word;
    logic                    rsp_pending = 1'b0;
    int                      stall_left = 0;
    int                      rsp_left = 0;
    int                      cycle_cnt = 0;
    int                      ready_low = 0;
    int                      accepted;
    int                      offered;

    lsu_top DUT (.*);

    bind lsu_top lsu_top_chk u_chk (
        .clk             ( clk             ),
        .rst_n_i         ( rst_n_i         ),
        .ext_req_valid_o ( ext_req_valid_o ),
        .ext_req_ready_i ( ext_req_ready_i ),
        .ext_req_o       ( ext_req_o       ),
        .rsp_valid_o     ( rsp_valid_o     )
    );

    always #20 clk = ~clk;

    task automatic stop_run();
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic report_mismatch(input string what, input logic [127:0] got,
                                   input logic [127:0] exp);
        $display("MISMATCH at time %0t: %s got %0h expected %0h", $time, what, got, exp);
        stop_run();
    endtask

    // untouched slave words read back as a pattern of their own address
    function automatic logic [63:0] fill_word(input logic [31:0] wa);
        return {~wa, wa};
    endfunction

    function automatic logic [63:0] load_value(input logic [63:0] w, input int off,
                                               input int sz, input logic sgn);
        logic [63:0] v;
        logic [63:0] hi;
        v = w >> (8 * off);
        if (sz == 8) return v;
        hi = ~64'd0 << (8 * sz);
        return (sgn && v[8 * sz - 1]) ? (v | hi) : (v & ~hi);
    endfunction

    function automatic logic [63:0] store_bytes(input logic [63:0] w, input int off,
                                                input int sz, input logic [63:0] d);
        for (int i = 0; i < sz; i++) begin
            w[8 * (off + i) +: 8] = d[8 * i +: 8];
        end
        return w;
    endfunction

    // store data as seen on the bus, low bytes copied into every lane
    function automatic logic [63:0] replicate(input logic [63:0] d, input int sz);
        logic [63:0] r;
        for (int i = 0; i < 8; i++) begin
            r[8 * i +: 8] = d[8 * (i % sz) +: 8];
        end
        return r;
    endfunction

    function automatic lsu_cmd_pkg::lsu_cmd_t make_cmd(input int n);
        lsu_cmd_pkg::lsu_cmd_t c;
        int                    sel;
        int                    off;
        logic [31:0]           hi;
        logic [31:0]           lo;
        c.op        = ($urandom_range(1, 0) == 1) ? lsu_cmd_pkg::op_store : lsu_cmd_pkg::op_load;
        c.width     = lsu_cmd_pkg::mem_width_e'(2'($urandom_range(3, 0)));
        c.is_signed = ($urandom_range(1, 0) == 1);
        c.wdata     = {$urandom, $urandom};
        off = int'($urandom_range(7, 0)) & ~((1 << c.width) - 1);
        hi  = 32'($urandom_range(16'hffff, 0)) << 11;
        lo  = 32'($urandom_range(15, 0)) << 3;
        sel = int'($urandom_range(15, 0));
        // first commands fill all cached words in use, so no load reads an unwritten word
        if (n < PRELOAD) begin
            c.op    = lsu_cmd_pkg::op_store;
            c.width = lsu_cmd_pkg::width_double;
            c.addr  = `LSU_CACHED_BASE | hi | (32'(n) << 3);
        end else begin
            case (sel)
                10:      c.addr = `LSU_CACHED_BASE;
                11:      c.addr = `LSU_CACHED_LIMIT;
                12:      c.addr = `LSU_CACHED_BASE - 32'd8;
                13:      c.addr = `LSU_CACHED_LIMIT + 32'd8;
                14:      c.addr = 32'h1000_0000 | lo | 32'(off);
                15:      c.addr = 32'h9000_0000 | lo | 32'(off);
                default: c.addr = `LSU_CACHED_BASE | hi | lo | 32'(off);
            endcase
        end
        return c;
    endfunction

    // expected response and bus request, worked out at acceptance
    task automatic predict(input lsu_cmd_pkg::lsu_cmd_t c);
        lsu_cmd_pkg::lsu_rsp_t r;
        mem_bus_pkg::bus_req_t e;
        logic [31:0]           wa;
        logic [63:0]           word;
        int                    off;
        int                    sz;
        int                    idx;
        off        = int'(c.addr[2:0]);
        sz         = 1 << c.width;
        wa         = {c.addr[31:3], 3'b000};
        idx        = int'(c.addr[10:3]);
        r.is_store = (c.op == lsu_cmd_pkg::op_store);
        r.uncached = (c.addr < `LSU_CACHED_BASE) || (c.addr > `LSU_CACHED_LIMIT);
        r.rdata    = '0;
        word = r.uncached ? (ref_ext.exists(wa) ? ref_ext[wa] : fill_word(wa)) : ref_ram[idx];
        if (r.is_store) begin
            word = store_bytes(word, off, sz, c.wdata);
        end else begin
            r.rdata = load_value(word, off, sz, c.is_signed);
        end
        if (r.uncached) begin
            ref_ext[wa]   = word;
            e.we          = r.is_store;
            e.uncached    = 1'b1;
            e.addr        = c.addr;
            e.strb        = 8'(((1 << sz) - 1) << off);
            e.wdata.dword = replicate(c.wdata, sz);
            e.width       = c.width;
            e.is_signed   = c.is_signed;
            ext_exp_q.push_back(e);
        end else begin
            ref_ram[idx] = word;
        end
        exp_q.push_back(r);
    endtask

    task automatic check_ext_req(input mem_bus_pkg::bus_req_t got);
        assert (ext_exp_q.size() != 0)
            else report_error("external request with no uncached command pending");
        exp_req = ext_exp_q.pop_front();
        assert (got.we === exp_req.we && got.addr === exp_req.addr)
            else report_mismatch("ext we/addr", 128'({got.we, got.addr}),
                                 128'({exp_req.we, exp_req.addr}));
        assert (got.strb === exp_req.strb)
            else report_mismatch("ext strb", 128'(got.strb), 128'(exp_req.strb));
        assert (!got.we || got.wdata === exp_req.wdata)
            else report_mismatch("ext wdata", 128'(got.wdata), 128'(exp_req.wdata));
        assert (got.uncached === exp_req.uncached && got.width === exp_req.width
                && got.is_signed === exp_req.is_signed)
            else report_mismatch("ext tag", 128'({got.uncached, got.width, got.is_signed}),
                                 128'({exp_req.uncached, exp_req.width, exp_req.is_signed}));
    endtask

    // ************************************************************
    // external slave, random stalls and response delay
    // ************************************************************
    always @(posedge clk) begin
        if (!rst_n_i) begin
            ext_req_ready_i <= 1'b0;
            ext_rsp_valid_i <= 1'b0;
            rsp_pending      = 1'b0;
            stall_left       = int'($urandom_range(7, 0));
        end else begin
            ext_rsp_valid_i <= 1'b0;
            if (rsp_pending && rsp_left <= 1) begin
                ext_rsp_valid_i   <= 1'b1;
                ext_rdata_i.dword <= slave_word;
                rsp_pending        = 1'b0;
            end else if (rsp_pending) begin
                rsp_left--;
            end
            if (ext_req_valid_o && ext_req_ready_i) begin
                check_ext_req(ext_req_o);
                slave_word = slave_mem.exists({ext_req_o.addr[31:3], 3'b000})
                           ? slave_mem[{ext_req_o.addr[31:3], 3'b000}]
                           : fill_word({ext_req_o.addr[31:3], 3'b000});
                for (int i = 0; i < 8; i++) begin
                    if (ext_req_o.we && ext_req_o.strb[i]) begin
                        slave_word[8 * i +: 8] = ext_req_o.wdata.lane[i];
                    end
                end
                slave_mem[{ext_req_o.addr[31:3], 3'b000}] = slave_word;
                ext_req_ready_i <= 1'b0;
                rsp_pending      = 1'b1;
                rsp_left         = int'($urandom_range(4, 1));
                stall_left       = int'($urandom_range(7, 0));
            end else if (ext_req_valid_o && stall_left == 0) begin
                ext_req_ready_i <= 1'b1;
            end else if (ext_req_valid_o) begin
                stall_left--;
            end
        end
    end

    // response check, in command order
    always @(posedge clk) begin
        if (rst_n_i && rsp_valid_o) begin
            assert (exp_q.size() != 0)
                else report_error("response with no command outstanding");
            exp_rsp = exp_q.pop_front();
            assert (rsp_o === exp_rsp)
                else report_mismatch("response", 128'(rsp_o), 128'(exp_rsp));
        end
    end

    // protocol rules of the bound checker
    always @(posedge clk) begin
        assert (DUT.u_chk.fail_cnt == 0)
            else report_error("a bus or response protocol rule was broken");
    end

    always @(posedge clk) begin
        cycle_cnt++;
        assert (cycle_cnt < MAX_CYCLES)
            else report_error($sformatf("timeout, run still busy after %0d cycles", cycle_cnt));
    end

    initial begin
        void'($urandom(SEED));
        rst_n_i     = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
        @(posedge clk);
        assert (cmd_ready_o && !rsp_valid_o && !ext_req_valid_o)
            else report_error("outputs not idle after reset");
        accepted = 0;
        offered  = 0;
        while (accepted < NUM_CMDS) begin
            if (cmd_valid_i && cmd_ready_o) begin
                predict(cmd_i);
                accepted++;
            end
            if (!cmd_valid_i || cmd_ready_o) begin
                if (offered < NUM_CMDS && $urandom_range(7, 0) != 0) begin
                    cmd_i       <= make_cmd(offered);
                    cmd_valid_i <= 1'b1;
                    offered++;
                end else begin
                    cmd_valid_i <= 1'b0;
                end
            end
            if (!cmd_ready_o) ready_low++;
            @(posedge clk);
        end
        while (exp_q.size() != 0) @(posedge clk);
        repeat (8) @(posedge clk);
        assert (ext_exp_q.size() == 0)
            else report_error("uncached command never reached the external bus");
        assert (ready_low > 0)
            else report_error("cmd_ready_o never dropped under slave stalls");
        $display("all tests passed");
        $finish;
    end

endmodule

//--- lsu_top.f
+incdir+verilog
verilog/lsu_cmd_pkg.sv
verilog/mem_bus_pkg.sv
verilog/lsu_req_gen.sv
verilog/lsu_req_fifo.sv
verilog/lsu_mem_port.sv
verilog/lsu_top.sv
test/lsu_top_chk.sv
test/lsu_top_tb.sv

//--- Makefile
# Verilator build and run for the load/store unit testbench

TOP       ?= lsu_top_tb
VERILATOR ?= verilator
BUILD_DIR ?= build
SEED_LOG  ?= sim.log
FILELIST  ?= lsu_top.f
VFLAGS    ?= --binary --assert --timescale 1ns/1ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulator exit code is ignored, the log decides pass or fail
run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(SEED_LOG) 2>&1
	@cat $(SEED_LOG)
	@grep -q "all tests passed" $(SEED_LOG)

clean:
	rm -rf $(BUILD_DIR) $(SEED_LOG)
